/* design/cache_pkg.sv */
package cache_pkg;

    // address split: tag, set, byte offset from the top down
    localparam int WORD_W    = 32;
    localparam int TAG_W     = 6;
    localparam int SET_W     = 4;
    localparam int OFFSET_W  = 2;
    localparam int NUM_SETS  = 1 << SET_W;
    localparam int MEM_WORDS = 1 << (TAG_W + SET_W);

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [SET_W-1:0]    set_index_t;
    typedef logic [OFFSET_W-1:0] byte_offset_t;

    typedef logic [TAG_W+SET_W+OFFSET_W-1:0] byte_addr_t;
    typedef logic [TAG_W+SET_W-1:0]          mem_addr_t;   // word address, tag then set

    // field positions inside one way, valid/dirty/tag/word from the top down
    localparam int WORD_LSB  = 0;
    localparam int TAG_LSB   = WORD_LSB + WORD_W;
    localparam int DIRTY_POS = TAG_LSB + TAG_W;
    localparam int VALID_POS = DIRTY_POS + 1;
    localparam int WAY_W     = VALID_POS + 1;

    // way 0 sits at the bottom, way 1 above it, lru bit on top
    localparam int LRU_POS   = 2 * WAY_W;

    typedef logic [LRU_POS:0] set_entry_t;

endpackage

/* design/cache_set_store.sv */
`timescale 1ns/100ps

module cache_set_store (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cache_pkg::set_index_t rd_index,
    input  logic                  wr_en,
    input  cache_pkg::set_index_t wr_index,
    input  cache_pkg::set_entry_t wr_entry,
    output cache_pkg::set_entry_t rd_entry
);
    import cache_pkg::*;

    set_entry_t entries [NUM_SETS];

    // walks the lower half of the sets, the upper half is cleared alongside
    logic [SET_W-2:0] clear_cnt;

    // two entries per reset cycle, so the whole array is clean after
    // NUM_SETS/2 cycles whatever value the counter wakes up with
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clear_cnt <= clear_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            entries[{1'b0, clear_cnt}] <= '0;
            entries[{1'b1, clear_cnt}] <= '0;
        end else if (wr_en) begin
            entries[wr_index] <= wr_entry; // commit from the response stage
        end
    end

    // synchronous read, data shows up the cycle after the index
    always_ff @(posedge clk) begin
        rd_entry <= entries[rd_index];
    end

endmodule

/* design/cache_backing_memory.sv */
`timescale 1ns/100ps

module cache_backing_memory (
    input  logic                 clk,
    input  cache_pkg::mem_addr_t rd_addr,
    input  logic                 wr_en,
    input  cache_pkg::mem_addr_t wr_addr,
    input  cache_pkg::word_t     wr_data,
    output cache_pkg::word_t     rd_data
);
    import cache_pkg::*;

    word_t mem [MEM_WORDS];

    // main memory starts out all zero
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data; // dirty victim write-back
        end
        rd_data <= mem[rd_addr];     // fill word, used on a miss only
    end

endmodule

/* design/cache_request_stage.sv */
`timescale 1ns/100ps

module cache_request_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid,
    input  logic                    req_write,
    input  logic                    req_byte,
    input  cache_pkg::byte_addr_t   req_addr,
    input  cache_pkg::word_t        req_wdata,
    input  logic                    advance,
    output logic                    req_ready,
    output cache_pkg::set_index_t   set_rd_index,
    output cache_pkg::mem_addr_t    mem_rd_addr,
    output logic                    s1_valid,
    output logic                    s1_write,
    output logic                    s1_byte,
    output cache_pkg::tag_t         s1_tag,
    output cache_pkg::set_index_t   s1_set,
    output cache_pkg::byte_offset_t s1_offset,
    output cache_pkg::word_t        s1_wdata
);
    import cache_pkg::*;

    tag_t         req_tag;
    set_index_t   req_set;
    byte_offset_t req_offset;
    logic         s1_free;
    logic         same_set_stall;
    logic         accept;

    assign {req_tag, req_set, req_offset} = req_addr;

    assign s1_free = !s1_valid || advance;

    // the line in stage one may still be rewritten, so a request to the
    // same set waits one cycle and reads the committed copy
    assign same_set_stall = s1_valid && (req_set == s1_set);

    assign req_ready = s1_free && !same_set_stall;
    assign accept    = req_valid && req_ready;

    // while stage one holds, keep re-reading its own line so the
    // registered read data stays with it
    assign set_rd_index = accept ? req_set : s1_set;
    assign mem_rd_addr  = accept ? {req_tag, req_set} : {s1_tag, s1_set};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else if (s1_free) begin
            s1_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_write  <= req_write;
            s1_byte   <= req_byte;
            s1_tag    <= req_tag;
            s1_set    <= req_set;
            s1_offset <= req_offset;
            s1_wdata  <= req_wdata;
        end
    end

endmodule

/* design/cache_way_select.sv */
`timescale 1ns/100ps

module cache_way_select (
    input  logic                    s1_write,
    input  logic                    s1_byte,
    input  cache_pkg::tag_t         s1_tag,
    input  cache_pkg::set_index_t   s1_set,
    input  cache_pkg::byte_offset_t s1_offset,
    input  cache_pkg::word_t        s1_wdata,
    input  cache_pkg::set_entry_t   set_entry,
    input  cache_pkg::word_t        fill_word,
    output cache_pkg::set_entry_t   updated_entry,
    output logic                    set_changed,
    output logic                    hit,
    output cache_pkg::word_t        load_data,
    output logic                    evict_write,
    output cache_pkg::mem_addr_t    evict_addr,
    output cache_pkg::word_t        evict_word
);
    import cache_pkg::*;

    // fields of the set as read
    logic       lru;
    logic [1:0] way_valid;
    logic [1:0] way_dirty;
    logic [1:0] way_hit;
    tag_t       way_tag [2];
    word_t      way_word [2];

    // fields after fill and store merge
    logic       new_lru;
    logic [1:0] new_valid;
    logic [1:0] new_dirty;
    tag_t       new_tag [2];
    word_t      new_word [2];

    logic       victim;   // way to evict on a miss
    logic       use_way;  // way that ends up holding the line
    word_t      sel_word;

    always_comb begin
        lru = set_entry[LRU_POS];
        for (int w = 0; w < 2; w++) begin
            way_valid[w] = set_entry[w*WAY_W + VALID_POS];
            way_dirty[w] = set_entry[w*WAY_W + DIRTY_POS];
            way_tag[w]   = set_entry[w*WAY_W + TAG_LSB +: TAG_W];
            way_word[w]  = set_entry[w*WAY_W + WORD_LSB +: WORD_W];
            way_hit[w]   = way_valid[w] && (way_tag[w] == s1_tag);
        end
    end

    assign hit     = |way_hit;
    assign victim  = !way_valid[1] || lru; // an empty way 1 is taken first
    assign use_way = hit ? way_hit[1] : victim;

    always_comb begin
        new_valid = way_valid;
        new_dirty = way_dirty;
        new_tag   = way_tag;
        new_word  = way_word;

        evict_write = 1'b0;
        evict_addr  = {way_tag[victim], s1_set};
        evict_word  = way_word[victim];

        if (!hit) begin
            // only a valid dirty line has to go back to memory
            evict_write       = way_valid[victim] && way_dirty[victim];
            new_valid[victim] = 1'b1;
            new_dirty[victim] = 1'b0;       // fresh from memory
            new_tag[victim]   = s1_tag;
            new_word[victim]  = fill_word;
        end

        sel_word = new_word[use_way];
        if (s1_write) begin
            if (s1_byte) begin
                sel_word[s1_offset*8 +: 8] = s1_wdata[7:0];
            end else begin
                sel_word = s1_wdata;
            end
            new_word[use_way]  = sel_word;
            new_dirty[use_way] = 1'b1;
        end

        new_lru = !use_way; // point at the way not just used
    end

    // byte loads are zero-extended
    assign load_data = s1_byte ? {{(WORD_W-8){1'b0}}, sel_word[s1_offset*8 +: 8]}
                               : sel_word;

    always_comb begin
        updated_entry          = '0;
        updated_entry[LRU_POS] = new_lru;
        for (int w = 0; w < 2; w++) begin
            updated_entry[w*WAY_W + VALID_POS]          = new_valid[w];
            updated_entry[w*WAY_W + DIRTY_POS]          = new_dirty[w];
            updated_entry[w*WAY_W + TAG_LSB +: TAG_W]   = new_tag[w];
            updated_entry[w*WAY_W + WORD_LSB +: WORD_W] = new_word[w];
        end
    end

    // a load hit on the lru way still flips the lru bit
    assign set_changed = (updated_entry != set_entry);

endmodule

/* design/cache_response_stage.sv */
`timescale 1ns/100ps

module cache_response_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             s1_valid,
    input  cache_pkg::word_t load_data,
    input  logic             hit,
    input  logic             resp_ready,
    output logic             advance,
    output logic             resp_valid,
    output cache_pkg::word_t resp_data,
    output logic             resp_hit
);

    // slot is free when empty or being drained this cycle
    assign advance = s1_valid && (!resp_valid || resp_ready);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else if (advance) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0; // handshake with nothing behind it
        end
    end

    // held steady while the consumer stalls
    always_ff @(posedge clk) begin
        if (advance) begin
            resp_data <= load_data;
            resp_hit  <= hit;
        end
    end

endmodule

/* design/data_cache_top.sv */
`timescale 1ns/100ps

module data_cache_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    input  logic                  req_write,
    input  logic                  req_byte,
    input  cache_pkg::byte_addr_t req_addr,
    input  cache_pkg::word_t      req_wdata,
    input  logic                  resp_ready,
    output logic                  req_ready,
    output logic                  resp_valid,
    output cache_pkg::word_t      resp_data,
    output logic                  resp_hit
);
    import cache_pkg::*;

    logic         advance;
    set_index_t   set_rd_index;
    mem_addr_t    mem_rd_addr;
    set_entry_t   rd_entry;
    word_t        fill_word;

    logic         s1_valid;
    logic         s1_write;
    logic         s1_byte;
    tag_t         s1_tag;
    set_index_t   s1_set;
    byte_offset_t s1_offset;
    word_t        s1_wdata;

    set_entry_t   updated_entry;
    logic         set_changed;
    logic         hit;
    word_t        load_data;
    logic         evict_write;
    mem_addr_t    evict_addr;
    word_t        evict_word;

    logic         set_wr_en;
    logic         mem_wr_en;

    // commits happen only on the edge that moves stage one forward
    assign set_wr_en = advance && set_changed;
    assign mem_wr_en = advance && evict_write;

    cache_request_stage i_cache_request_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_write    (req_write),
        .req_byte     (req_byte),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .advance      (advance),
        .req_ready    (req_ready),
        .set_rd_index (set_rd_index),
        .mem_rd_addr  (mem_rd_addr),
        .s1_valid     (s1_valid),
        .s1_write     (s1_write),
        .s1_byte      (s1_byte),
        .s1_tag       (s1_tag),
        .s1_set       (s1_set),
        .s1_offset    (s1_offset),
        .s1_wdata     (s1_wdata)
    );

    cache_set_store i_cache_set_store (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_index (set_rd_index),
        .wr_en    (set_wr_en),
        .wr_index (s1_set),
        .wr_entry (updated_entry),
        .rd_entry (rd_entry)
    );

    cache_backing_memory i_cache_backing_memory (
        .clk     (clk),
        .rd_addr (mem_rd_addr),
        .wr_en   (mem_wr_en),
        .wr_addr (evict_addr),
        .wr_data (evict_word),
        .rd_data (fill_word)
    );

    cache_way_select i_cache_way_select (
        .s1_write      (s1_write),
        .s1_byte       (s1_byte),
        .s1_tag        (s1_tag),
        .s1_set        (s1_set),
        .s1_offset     (s1_offset),
        .s1_wdata      (s1_wdata),
        .set_entry     (rd_entry),
        .fill_word     (fill_word),
        .updated_entry (updated_entry),
        .set_changed   (set_changed),
        .hit           (hit),
        .load_data     (load_data),
        .evict_write   (evict_write),
        .evict_addr    (evict_addr),
        .evict_word    (evict_word)
    );

    cache_response_stage i_cache_response_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .s1_valid   (s1_valid),
        .load_data  (load_data),
        .hit        (hit),
        .resp_ready (resp_ready),
        .advance    (advance),
        .resp_valid (resp_valid),
        .resp_data  (resp_data),
        .resp_hit   (resp_hit)
    );

endmodule

/* sim/clock_gen.sv */
`timescale 1ns/100ps

module clock_gen (
    output logic clk,
    output logic rst_n
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1; // released just after the tenth edge
    end

endmodule

/* sim/data_cache_tb.sv */
`timescale 1ns/100ps

module data_cache_tb;
    import cache_pkg::*;

    // request counts of the six tests, in order
    localparam int TOTAL_REQS  = 16 + 6 + 5 + 8 + 40 + 400;
    localparam int CYCLE_LIMIT = 4 * TOTAL_REQS + 200;

    logic       clk;
    logic       rst_n;
    logic       req_valid;
    logic       req_ready;
    logic       req_write;
    logic       req_byte;
    byte_addr_t req_addr;
    word_t      req_wdata;
    logic       resp_ready;
    logic       resp_valid;
    word_t      resp_data;
    logic       resp_hit;

    logic [31:0] rng_state = 32'd76;
    logic [31:0] stall_state = 32'd76; // own stream for the resp_ready driver
    int          stall_pct = 0;   // chance of resp_ready low, in percent
    int          errors = 0;
    int          err_base = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          cycles = 0;

    // reference model: memory as the requester sees it, plus tags and lru per set
    word_t ref_mem [MEM_WORDS];
    logic  model_valid [NUM_SETS][2];
    tag_t  model_tag [NUM_SETS][2];
    logic  model_lru [NUM_SETS];
    word_t exp_data_q [$];
    logic  exp_hit_q [$];

    clock_gen i_clock_gen (.clk(clk), .rst_n(rst_n));

    data_cache_top i_data_cache_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .req_byte   (req_byte),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .resp_ready (resp_ready),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_data  (resp_data),
        .resp_hit   (resp_hit)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic word_t store_merge(input word_t old, input logic byte_op,
                                          input byte_offset_t off, input word_t wdata);
        word_t mask;
        mask = 32'hFF << (8 * off);
        if (!byte_op) begin
            return wdata;
        end
        return (old & ~mask) | ((wdata & 32'hFF) << (8 * off));
    endfunction

    // what the response should carry: the word after any store, or its byte
    function automatic word_t expected_data(input word_t old, input logic write,
                                            input logic byte_op, input byte_offset_t off,
                                            input word_t wdata);
        word_t w;
        w = write ? store_merge(old, byte_op, off, wdata) : old;
        return byte_op ? ((w >> (8 * off)) & 32'hFF) : w;
    endfunction

    function automatic void model_access(input logic write, input logic byte_op,
                                         input byte_addr_t addr, input word_t wdata);
        tag_t         tag;
        set_index_t   idx;
        byte_offset_t off;
        mem_addr_t    waddr;
        logic         hit0;
        logic         hit1;
        logic         way;
        {tag, idx, off} = addr;
        waddr = {tag, idx};
        hit0 = model_valid[idx][0] && (model_tag[idx][0] == tag);
        hit1 = model_valid[idx][1] && (model_tag[idx][1] == tag);
        if (hit1 || hit0) begin
            way = hit1;
        end else begin
            way = !model_valid[idx][1] || model_lru[idx]; // empty way 1 first, else lru
        end
        exp_hit_q.push_back(hit0 || hit1);
        exp_data_q.push_back(expected_data(ref_mem[waddr], write, byte_op, off, wdata));
        if (write) begin
            ref_mem[waddr] = store_merge(ref_mem[waddr], byte_op, off, wdata);
        end
        model_valid[idx][way] = 1'b1;
        model_tag[idx][way]   = tag;
        model_lru[idx]        = !way;
    endfunction

    // called 1 ns after a rising edge, returns 1 ns after the accepting edge
    task automatic send_request(input logic write, input logic byte_op,
                                input byte_addr_t addr, input word_t wdata);
        logic taken;
        taken     = 1'b0;
        req_valid = 1'b1;
        req_write = write;
        req_byte  = byte_op;
        req_addr  = addr;
        req_wdata = wdata;
        while (!taken) begin
            @(negedge clk);
            taken = req_ready; // inputs settled since the drive point
            if (taken) begin
                model_access(write, byte_op, addr, wdata);
            end
            @(posedge clk);
            #1;
        end
        req_valid = 1'b0;
    endtask

    // narrow range: tags 0..3 over sets 0..3
    task automatic random_request();
        logic [31:0]  r;
        logic         byte_op;
        byte_offset_t off;
        r       = next_rand();
        byte_op = r[1];
        off     = byte_op ? r[7:6] : 2'd0;
        send_request(r[0], byte_op, {4'd0, r[3:2], 2'd0, r[5:4], off}, next_rand());
    endtask

    task automatic finish_test(input string name);
        while (exp_data_q.size() > 0) begin
            @(posedge clk);
            #1;
        end
        if (errors == err_base) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_base);
        end
        err_base = errors;
    endtask

    // resp_ready, random stalls when stall_pct is set
    initial begin
        resp_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            stall_state = xorshift32(stall_state);
            resp_ready  = (stall_pct == 0) || ((stall_state % 32'd100) >= 32'(stall_pct));
        end
    end

    // response checker, samples at the falling edge
    initial begin
        logic  held;
        word_t held_data;
        logic  held_hit;
        word_t exp_d;
        logic  exp_h;
        held = 1'b0;
        forever begin
            @(negedge clk);
            if (rst_n) begin
                if (held) begin
                    assert (resp_valid && resp_data == held_data && resp_hit == held_hit)
                    else begin
                        $display("Mismatch at %0t: response changed while stalled", $time);
                        errors++;
                    end
                end
                if (resp_valid && resp_ready) begin
                    assert (exp_data_q.size() > 0) else begin
                        $display("unexpected response at %0t with no request outstanding",
                                 $time);
                        errors++;
                    end
                    if (exp_data_q.size() > 0) begin
                        exp_d = exp_data_q.pop_front();
                        exp_h = exp_hit_q.pop_front();
                        assert (resp_data == exp_d && resp_hit == exp_h) else begin
                            $display("Mismatch at %0t: data %h hit %b, expected data %h hit %b",
                                     $time, resp_data, resp_hit, exp_d, exp_h);
                            errors++;
                        end
                    end
                end
                held      = resp_valid && !resp_ready;
                held_data = resp_data;
                held_hit  = resp_hit;
            end
        end
    end

    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
        $display("Regression failed");
        $finish;
    end

    initial begin
        req_valid = 1'b0;
        req_write = 1'b0;
        req_byte  = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        for (int s = 0; s < NUM_SETS; s++) begin
            model_valid[s][0] = 1'b0;
            model_valid[s][1] = 1'b0;
            model_tag[s][0]   = '0;
            model_tag[s][1]   = '0;
            model_lru[s]      = 1'b0;
        end
        wait (rst_n);
        @(posedge clk);
        #1;
        assert (!resp_valid && req_ready) else begin
            $display("DUT is not idle after reset");
            errors++;
        end

        for (int i = 0; i < 8; i++) begin
            send_request(1'b1, 1'b0, {6'd1, 4'(i), 2'd0}, next_rand());
        end
        for (int i = 0; i < 8; i++) begin
            send_request(1'b0, 1'b0, {6'd1, 4'(i), 2'd0}, '0);
        end
        finish_test("load after store");

        send_request(1'b1, 1'b0, {6'd2, 4'd12, 2'd0}, 32'h1122_3344);
        send_request(1'b1, 1'b1, {6'd2, 4'd12, 2'd1}, 32'hDEAD_BEA5); // only a5 lands
        send_request(1'b1, 1'b1, {6'd2, 4'd12, 2'd3}, 32'h0BAD_F05C);
        send_request(1'b0, 1'b1, {6'd2, 4'd12, 2'd1}, '0);
        send_request(1'b0, 1'b1, {6'd2, 4'd12, 2'd0}, '0);
        send_request(1'b0, 1'b0, {6'd2, 4'd12, 2'd0}, '0);
        finish_test("byte access");

        // three tags on set 5, the first one is pushed out dirty
        send_request(1'b1, 1'b0, {6'd3, 4'd5, 2'd0}, next_rand());
        send_request(1'b1, 1'b0, {6'd4, 4'd5, 2'd0}, next_rand());
        send_request(1'b1, 1'b0, {6'd7, 4'd5, 2'd0}, next_rand());
        send_request(1'b0, 1'b0, {6'd3, 4'd5, 2'd0}, '0);
        send_request(1'b0, 1'b0, {6'd7, 4'd5, 2'd0}, '0);
        finish_test("eviction and write-back");

        send_request(1'b1, 1'b0, {6'd10, 4'd9, 2'd0}, next_rand());
        send_request(1'b0, 1'b0, {6'd10, 4'd9, 2'd0}, '0);
        send_request(1'b1, 1'b0, {6'd11, 4'd10, 2'd0}, next_rand());
        send_request(1'b0, 1'b0, {6'd10, 4'd9, 2'd0}, '0);
        send_request(1'b1, 1'b1, {6'd10, 4'd9, 2'd2}, next_rand());
        send_request(1'b0, 1'b0, {6'd11, 4'd10, 2'd0}, '0);
        send_request(1'b0, 1'b0, {6'd10, 4'd9, 2'd0}, '0);
        send_request(1'b0, 1'b0, {6'd11, 4'd10, 2'd0}, '0);
        finish_test("same-set hazard");

        stall_pct = 50;
        for (int i = 0; i < 40; i++) begin
            random_request();
        end
        finish_test("back-pressure");

        stall_pct = 20;
        for (int i = 0; i < 400; i++) begin
            random_request();
        end
        finish_test("random regression");

        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* src.f */
design/cache_pkg.sv
design/cache_set_store.sv
design/cache_backing_memory.sv
design/cache_request_stage.sv
design/cache_way_select.sv
design/cache_response_stage.sv
design/data_cache_top.sv
sim/clock_gen.sv
sim/data_cache_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module data_cache_tb -o vsim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/vsim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" sim.log; then
    exit 1
fi
exit 0
